// File: wts_channel_mixer.f
+incdir+common
common/wts_pkg.sv
channel/wts_channel_part.sv
wave_bank/wts_channel_volume.sv
wave_bank/wts_wave_bank.sv
rtl/wts_cpu_access.sv
rtl/wts_stereo_mixer.sv
rtl/wts_channel_mixer.sv
verif/wts_tb_checker.sv
verif/tb_wts_channel_mixer.sv

// File: Makefile
TOP = tb_wts_channel_mixer

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f wts_channel_mixer.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f wts_channel_mixer.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: verif/tb_wts_channel_mixer.sv
/*
	Testbench of the wave-table mixer with a byte model of both wave RAMs.
	Inputs change on the falling edge, and every task returns on one.
	Tone checks fill whole channel waves with a constant, so the wave address
	and the frequency count do not move the expected outputs.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_tb_clock (
	output	logic	clk,
	output	logic	nreset
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		nreset = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;
	end

endmodule

module tb_wts_channel_mixer import wts_pkg::*; ();

	localparam int N_CH				= `WTS_BANKS * `WTS_CH_PER_BANK;
	localparam int N_RW				= 32;
	localparam int ROUNDS			= 3;
	localparam int N_ACCESS			= 2 * N_RW + 128 + ROUNDS * N_CH * 128;
	localparam int N_TONE			= 3 + 1 + ROUNDS + N_CH + 2;
	localparam int WATCHDOG_CYCLES	= N_ACCESS * 64 + N_TONE * 40 + 2000;

	logic							clk;
	logic							nreset;
	wts_cpu_req_t					cpu;
	wts_channel_reg_t	[N_CH-1:0]	regs;
	wts_key_t			[N_CH-1:0]	keys;
	logic				[7:0]		sram_q;
	logic							sram_q_en;
	logic				[11:0]		left_out;
	logic				[11:0]		right_out;

	logic							rd_start;
	logic				[7:0]		exp_q;
	logic							out_check;
	logic				[11:0]		exp_left;
	logic				[11:0]		exp_right;
	logic							rd_busy;
	int								value_errors;
	int								protocol_errors;

	integer							seed = 32'h46be_32d7;
	logic				[7:0]		ram_model [0:1][0:1023];
	logic				[N_CH-1:0]	playing_m;
	logic							wr_bank [N_RW];
	logic				[2:0]		wr_ch [N_RW];
	logic				[6:0]		wr_a [N_RW];
	logic				[N_CH-1:0]	chosen;
	int								tone_idx;

	wts_tb_clock u_clock (
		.clk	(clk),
		.nreset	(nreset)
	);

	wts_channel_mixer wts_channel_mixer_i (
		.clk		(clk),
		.nreset		(nreset),
		.cpu		(cpu),
		.regs		(regs),
		.keys		(keys),
		.sram_q		(sram_q),
		.sram_q_en	(sram_q_en),
		.left_out	(left_out),
		.right_out	(right_out)
	);

	wts_tb_checker u_checker (
		.clk				(clk),
		.nreset				(nreset),
		.sram_q				(sram_q),
		.sram_q_en			(sram_q_en),
		.left_out			(left_out),
		.right_out			(right_out),
		.rd_start			(rd_start),
		.exp_q				(exp_q),
		.out_check			(out_check),
		.exp_left			(exp_left),
		.exp_right			(exp_right),
		.rd_busy			(rd_busy),
		.value_errors		(value_errors),
		.protocol_errors	(protocol_errors)
	);

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic integer scaled_sample(input logic [7:0] s, input logic [3:0] vol);
		integer s_int;
		integer v_int;
		integer prod;
		s_int = s;
		if (s[7]) begin
			s_int = s_int - 256;
		end
		v_int = vol;
		prod = s_int * v_int;
		return prod >>> 4;
	endfunction

	// Wave byte 0 stands for the whole constant wave of a channel
	function automatic logic [11:0] expected_side(input logic left_side);
		integer total;
		logic sel;
		logic bank;
		logic [2:0] ch;
		total = 0;
		for (int i = 0; i < N_CH; i++) begin
			sel = left_side ? regs[i].enable[1] : regs[i].enable[0];
			bank = 1'(i / `WTS_CH_PER_BANK);
			ch = 3'(i % `WTS_CH_PER_BANK);
			if (playing_m[i] && sel) begin
				total = total + scaled_sample(ram_model[bank][{ch, 7'd0}], regs[i].volume);
			end
		end
		return 12'(2048 + total);
	endfunction

	// ----------------------------------------------------------------------
	// Stimulus tasks
	// ----------------------------------------------------------------------
	// The next strobe must not arrive before the latest possible completion
	task automatic cpu_write(input logic bank, input logic [2:0] ch, input logic [6:0] a,
		input logic [7:0] d);
		cpu.id.bank = bank;
		cpu.id.channel = ch;
		cpu.a = a;
		cpu.d = d;
		cpu.oe = 1'b0;
		cpu.we = 1'b1;
		ram_model[bank][{ch, a}] = d;
		@(negedge clk);
		cpu.we = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	task automatic cpu_read(input logic bank, input logic [2:0] ch, input logic [6:0] a);
		cpu.id.bank = bank;
		cpu.id.channel = ch;
		cpu.a = a;
		cpu.oe = 1'b1;
		cpu.we = 1'b0;
		rd_start = 1'b1;
		exp_q = ram_model[bank][{ch, a}];
		@(negedge clk);
		cpu.oe = 1'b0;
		rd_start = 1'b0;
		while (rd_busy) @(negedge clk);
	endtask

	task automatic fill_wave(input int idx, input logic [7:0] val);
		logic bank;
		logic [2:0] ch;
		bank = 1'(idx / `WTS_CH_PER_BANK);
		ch = 3'(idx % `WTS_CH_PER_BANK);
		for (int a = 0; a < 128; a++) begin
			cpu_write(bank, ch, 7'(a), val);
		end
	endtask

	task automatic set_random_settings(input int idx);
		regs[idx].volume = 4'($random(seed));
		regs[idx].enable = 2'($random(seed));
		regs[idx].frequency_count = 12'($random(seed));
	endtask

	// Key on wins when a channel gets both, as in the channel
	task automatic pulse_keys(input logic [N_CH-1:0] on_mask, input logic [N_CH-1:0] off_mask);
		for (int i = 0; i < N_CH; i++) begin
			keys[i].key_on = on_mask[i];
			keys[i].key_off = off_mask[i];
		end
		playing_m = (playing_m & ~off_mask) | on_mask;
		@(negedge clk);
		keys = '0;
	endtask

	task automatic expect_outputs(input logic [11:0] l, input logic [11:0] r,
		input int frames, input logic shuffle);
		exp_left = l;
		exp_right = r;
		out_check = 1'b1;
		for (int f = 0; f < frames; f++) begin
			if (shuffle) begin
				for (int i = 0; i < N_CH; i++) begin
					if (playing_m[i]) begin
						regs[i].frequency_count = 12'($random(seed));
					end
				end
			end
			repeat (`WTS_SLOTS) @(negedge clk);
		end
		out_check = 1'b0;
	endtask

	// Four frames cover the three frames of settling
	task automatic check_mix(input int hold_frames, input logic shuffle);
		repeat (4 * `WTS_SLOTS) @(negedge clk);
		expect_outputs(expected_side(1'b1), expected_side(1'b0), hold_frames, shuffle);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		cpu = '0;
		regs = '0;
		keys = '0;
		rd_start = 1'b0;
		exp_q = '0;
		out_check = 1'b0;
		exp_left = 12'h800;
		exp_right = 12'h800;
		playing_m = '0;
		for (int b = 0; b < 2; b++) begin
			for (int a = 0; a < 1024; a++) begin
				ram_model[b][a] = '0;
			end
		end
		wait (nreset === 1'b1);
		@(negedge clk);

		expect_outputs(12'h800, 12'h800, 3, 1'b0);

		for (int n = 0; n < N_RW; n++) begin
			wr_bank[n] = 1'($random(seed));
			wr_ch[n] = 3'($random(seed));
			wr_a[n] = 7'($random(seed));
			cpu_write(wr_bank[n], wr_ch[n], wr_a[n], 8'($random(seed)));
		end
		for (int n = 0; n < N_RW; n++) begin
			cpu_read(wr_bank[n], wr_ch[n], wr_a[n]);
		end

		tone_idx = {$random(seed)} % N_CH;
		fill_wave(tone_idx, 8'($random(seed)));
		set_random_settings(tone_idx);
		pulse_keys(N_CH'(1) << tone_idx, '0);
		check_mix(3, 1'b1);

		for (int round = 0; round < ROUNDS; round++) begin
			pulse_keys('0, '1);
			chosen = N_CH'($random(seed));
			for (int i = 0; i < N_CH; i++) begin
				if (chosen[i]) begin
					fill_wave(i, 8'($random(seed)));
					set_random_settings(i);
				end
			end
			pulse_keys(chosen, '0);
			check_mix(2, 1'b0);
		end

		for (int i = 0; i < N_CH; i++) begin
			if (playing_m[i]) begin
				pulse_keys('0, N_CH'(1) << i);
				check_mix(1, 1'b0);
			end
		end
		expect_outputs(12'h800, 12'h800, 2, 1'b0);

		repeat (2) @(negedge clk);
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 8);
		$display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/wts_tb_checker.sv
/*
	Checker of the mixer outputs, sampled on the rising clock edge.
	A read is armed by rd_start in its strobe cycle, and the sram_q_en pulse
	must show within 7 cycles of that strobe.
	Output levels are compared in every cycle while out_check is high.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_tb_checker (
	input	wire logic						clk,
	input	wire logic						nreset,
	input	wire logic	[`WTS_SAMPLE_W-1:0]	sram_q,
	input	wire logic						sram_q_en,
	input	wire logic	[`WTS_OUT_W-1:0]	left_out,
	input	wire logic	[`WTS_OUT_W-1:0]	right_out,
	input	wire logic						rd_start,
	input	wire logic	[`WTS_SAMPLE_W-1:0]	exp_q,
	input	wire logic						out_check,
	input	wire logic	[`WTS_OUT_W-1:0]	exp_left,
	input	wire logic	[`WTS_OUT_W-1:0]	exp_right,
	output	logic							rd_busy,
	output	int								value_errors,
	output	int								protocol_errors
);

	logic						busy = 1'b0;
	logic	[`WTS_SAMPLE_W-1:0]	q_expected = '0;
	int							rd_wait = 0;
	int							n_value = 0;
	int							n_protocol = 0;

	always @(posedge clk) begin
		if (nreset) begin
			if (busy) begin
				if (sram_q_en) begin
					busy <= 1'b0;
					if (sram_q !== q_expected) begin
						$display("ERR sram_q expected 0x%02h actual 0x%02h at %0t",
							q_expected, sram_q, $time);
						n_value = n_value + 1;
					end
				end else if (rd_wait == 7) begin
					busy <= 1'b0;
					$display("Read at %0t got no sram_q_en pulse within 7 cycles", $time);
					n_protocol = n_protocol + 1;
				end else begin
					rd_wait <= rd_wait + 1;
				end
			end else begin
				if (sram_q_en) begin
					$display("Unexpected sram_q_en pulse without a pending read at %0t", $time);
					n_protocol = n_protocol + 1;
				end
				if (rd_start) begin
					busy		<= 1'b1;
					rd_wait		<= 1;
					q_expected	<= exp_q;
				end
			end

			// Outputs only move on the CPU slot, so every cycle in the window counts
			if (out_check) begin
				if (left_out !== exp_left) begin
					$display("ERR left_out expected 0x%03h actual 0x%03h at %0t",
						exp_left, left_out, $time);
					n_value = n_value + 1;
				end
				if (right_out !== exp_right) begin
					$display("ERR right_out expected 0x%03h actual 0x%03h at %0t",
						exp_right, right_out, $time);
					n_value = n_value + 1;
				end
			end
		end
	end

	assign rd_busy			= busy;
	assign value_errors		= n_value;
	assign protocol_errors	= n_protocol;

endmodule

`default_nettype wire

// File: rtl/wts_channel_mixer.sv
/*
	Wave-table mixer, two banks of five channels.
	regs and keys index 0 to 4 belong to bank 0, 5 to 9 to bank 1.
	Keys are one-cycle pulses. Every channel plays a 128-sample loop.
	Outputs are 12-bit offset binary, updated once per 6-cycle frame.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_channel_mixer import wts_pkg::*; (
	input	wire logic													clk,
	input	wire logic													nreset,
	input	wire wts_cpu_req_t											cpu,
	input	wire wts_channel_reg_t	[`WTS_BANKS*`WTS_CH_PER_BANK-1:0]	regs,
	input	wire wts_key_t			[`WTS_BANKS*`WTS_CH_PER_BANK-1:0]	keys,
	output	wire logic				[`WTS_SAMPLE_W-1:0]					sram_q,
	output	wire logic													sram_q_en,
	output	wire logic				[`WTS_OUT_W-1:0]					left_out,
	output	wire logic				[`WTS_OUT_W-1:0]					right_out
);

	wts_slot_t						slot;
	logic	[9:0]					cpu_a;
	logic	[`WTS_SAMPLE_W-1:0]		cpu_d;
	logic	[`WTS_BANKS-1:0]		bank_we;
	logic	[`WTS_SAMPLE_W-1:0]		bank_q0;
	logic	[`WTS_SAMPLE_W-1:0]		bank_q1;
	wts_stereo_t					sample0;
	wts_stereo_t					sample1;

	wts_cpu_access u_cpu_access (
		.clk		(clk),
		.nreset		(nreset),
		.cpu		(cpu),
		.bank_q0	(bank_q0),
		.bank_q1	(bank_q1),
		.slot		(slot),
		.cpu_a		(cpu_a),
		.cpu_d		(cpu_d),
		.bank_we	(bank_we),
		.sram_q		(sram_q),
		.sram_q_en	(sram_q_en)
	);

	wts_wave_bank u_wave_bank0 (
		.clk		(clk),
		.nreset		(nreset),
		.slot		(slot),
		.regs		(regs[`WTS_CH_PER_BANK-1:0]),
		.keys		(keys[`WTS_CH_PER_BANK-1:0]),
		.cpu_a		(cpu_a),
		.cpu_d		(cpu_d),
		.we			(bank_we[0]),
		.q			(bank_q0),
		.sample		(sample0)
	);

	wts_wave_bank u_wave_bank1 (
		.clk		(clk),
		.nreset		(nreset),
		.slot		(slot),
		.regs		(regs[2*`WTS_CH_PER_BANK-1:`WTS_CH_PER_BANK]),
		.keys		(keys[2*`WTS_CH_PER_BANK-1:`WTS_CH_PER_BANK]),
		.cpu_a		(cpu_a),
		.cpu_d		(cpu_d),
		.we			(bank_we[1]),
		.q			(bank_q1),
		.sample		(sample1)
	);

	wts_stereo_mixer u_stereo_mixer (
		.clk		(clk),
		.nreset		(nreset),
		.slot		(slot),
		.bank0		(sample0),
		.bank1		(sample1),
		.left_out	(left_out),
		.right_out	(right_out)
	);

endmodule

`default_nettype wire

// File: rtl/wts_stereo_mixer.sv
/*
	Sums both banks and integrates one frame of six cycles.
	Integration wraps modulo 4096, as does the output.
	Outputs are offset binary and only change on the CPU slot.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_stereo_mixer import wts_pkg::*; (
	input	wire logic						clk,
	input	wire logic						nreset,
	input	wire wts_slot_t					slot,
	input	wire wts_stereo_t				bank0,
	input	wire wts_stereo_t				bank1,
	output	logic		[`WTS_OUT_W-1:0]	left_out,
	output	logic		[`WTS_OUT_W-1:0]	right_out
);

	logic	[`WTS_SAMPLE_W:0]	left_sum;
	logic	[`WTS_SAMPLE_W:0]	right_sum;
	logic	[`WTS_OUT_W-1:0]	left_ext;
	logic	[`WTS_OUT_W-1:0]	right_ext;
	logic	[`WTS_OUT_W-1:0]	ff_left_integ;
	logic	[`WTS_OUT_W-1:0]	ff_right_integ;

	assign left_sum		= {bank0.left[`WTS_SAMPLE_W-1], bank0.left}
						+ {bank1.left[`WTS_SAMPLE_W-1], bank1.left};
	assign right_sum	= {bank0.right[`WTS_SAMPLE_W-1], bank0.right}
						+ {bank1.right[`WTS_SAMPLE_W-1], bank1.right};

	assign left_ext		= {{(`WTS_OUT_W-`WTS_SAMPLE_W-1){left_sum[`WTS_SAMPLE_W]}}, left_sum};
	assign right_ext	= {{(`WTS_OUT_W-`WTS_SAMPLE_W-1){right_sum[`WTS_SAMPLE_W]}}, right_sum};

	// ----------------------------------------------------------------------
	// Frame integrator and output registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_left_integ	<= '0;
			ff_right_integ	<= '0;
			left_out		<= {1'b1, {(`WTS_OUT_W-1){1'b0}}};
			right_out		<= {1'b1, {(`WTS_OUT_W-1){1'b0}}};
		end else if (slot[`WTS_CPU_SLOT]) begin
			ff_left_integ	<= left_ext;
			ff_right_integ	<= right_ext;
			left_out		<= {~ff_left_integ[`WTS_OUT_W-1], ff_left_integ[`WTS_OUT_W-2:0]};
			right_out		<= {~ff_right_integ[`WTS_OUT_W-1], ff_right_integ[`WTS_OUT_W-2:0]};
		end else begin
			ff_left_integ	<= ff_left_integ + left_ext;
			ff_right_integ	<= ff_right_integ + right_ext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/wts_cpu_access.sv
/*
	Slot sequencer and CPU port of the wave RAMs.
	oe and we are one-cycle strobes; a new strobe replaces a pending request.
	A request completes in the first CPU slot after its strobe, 1 to 6 cycles.
	Read data is valid with sram_q_en, one cycle after completion.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_cpu_access import wts_pkg::*; (
	input	wire logic								clk,
	input	wire logic								nreset,
	input	wire wts_cpu_req_t						cpu,
	input	wire logic	[`WTS_SAMPLE_W-1:0]			bank_q0,
	input	wire logic	[`WTS_SAMPLE_W-1:0]			bank_q1,
	output	wts_slot_t								slot,
	output	logic		[9:0]						cpu_a,
	output	logic		[`WTS_SAMPLE_W-1:0]			cpu_d,
	output	logic		[`WTS_BANKS-1:0]			bank_we,
	output	logic		[`WTS_SAMPLE_W-1:0]			sram_q,
	output	logic									sram_q_en
);

	wts_slot_t		ff_slot;
	wts_cpu_req_t	ff_req;
	logic			ff_q_en;
	logic			ff_rd_bank;
	logic			done;

	// ----------------------------------------------------------------------
	// Slot sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_slot <= wts_slot_t'(1);
		end else begin
			ff_slot <= {ff_slot[`WTS_SLOTS-2:0], ff_slot[`WTS_SLOTS-1]};
		end
	end

	assign slot = ff_slot;

	// ----------------------------------------------------------------------
	// Request latch
	// ----------------------------------------------------------------------
	assign done = (ff_req.oe || ff_req.we) && ff_slot[`WTS_CPU_SLOT];

	// Id, address and data only move with a strobe
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_req.oe	<= 1'b0;
			ff_req.we	<= 1'b0;
		end else if (cpu.oe || cpu.we) begin
			ff_req		<= cpu;
		end else if (done) begin
			ff_req.oe	<= 1'b0;
			ff_req.we	<= 1'b0;
		end
	end

	assign cpu_a = {ff_req.id.channel, ff_req.a};
	assign cpu_d = ff_req.d;

	always_comb begin
		bank_we = '0;
		if (done && ff_req.we) begin
			bank_we[ff_req.id.bank] = 1'b1;
		end
	end

	// Bank of the read is kept so a later strobe cannot switch sram_q
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_q_en		<= 1'b0;
			ff_rd_bank	<= 1'b0;
		end else begin
			ff_q_en		<= done && ff_req.oe;
			if (done) begin
				ff_rd_bank <= ff_req.id.bank;
			end
		end
	end

	assign sram_q_en	= ff_q_en;
	assign sram_q		= ff_rd_bank ? bank_q1 : bank_q0;

	a_slot_onehot: assert property (@(posedge clk) disable iff (!nreset)
		$onehot(ff_slot));

	a_q_en_after_cpu_slot: assert property (@(posedge clk) disable iff (!nreset)
		sram_q_en |-> $past(ff_slot[`WTS_CPU_SLOT]));

endmodule

`default_nettype wire

// File: wave_bank/wts_wave_bank.sv
/*
	One bank of five channels sharing a 1 KiB wave RAM.
	RAM address is {channel, sample index}; the CPU owns it in the CPU slot.
	Reads are registered, and the scaled sample of the channel in slot k
	leaves the bank two cycles after slot k.
	we must only be raised in the CPU slot.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_wave_bank import wts_pkg::*; (
	input	wire logic										clk,
	input	wire logic										nreset,
	input	wire wts_slot_t									slot,
	input	wire wts_channel_reg_t	[`WTS_CH_PER_BANK-1:0]	regs,
	input	wire wts_key_t			[`WTS_CH_PER_BANK-1:0]	keys,
	input	wire logic				[9:0]					cpu_a,
	input	wire logic				[`WTS_SAMPLE_W-1:0]		cpu_d,
	input	wire logic										we,
	output	logic					[`WTS_SAMPLE_W-1:0]		q,
	output	wts_stereo_t									sample
);

	logic	[`WTS_SAMPLE_W-1:0]		ram [0:1023];
	logic	[`WTS_SAMPLE_W-1:0]		ff_q;
	logic	[9:0]					ram_a;

	logic	[`WTS_CH_PER_BANK-1:0]	playing;
	logic	[`WTS_WAVE_ADDR_W-1:0]	wave_a [`WTS_CH_PER_BANK];

	logic	[`WTS_VOLUME_W-1:0]		cur_volume;
	logic	[1:0]					cur_enable;
	logic							cur_playing;
	logic	[`WTS_VOLUME_W-1:0]		ff_volume;
	logic	[1:0]					ff_enable;
	logic							ff_playing;

	// ----------------------------------------------------------------------
	// Channels
	// ----------------------------------------------------------------------
	for (genvar k = 0; k < `WTS_CH_PER_BANK; k++) begin : g_ch
		wts_channel_part u_channel_part (
			.clk				(clk),
			.nreset				(nreset),
			.active				(slot[k]),
			.key				(keys[k]),
			.frequency_count	(regs[k].frequency_count),
			.playing			(playing[k]),
			.wave_a				(wave_a[k])
		);
	end

	// Slot select of RAM address and channel settings
	always_comb begin
		ram_a		= cpu_a;
		cur_volume	= '0;
		cur_enable	= '0;
		cur_playing	= 1'b0;
		for (int k = 0; k < `WTS_CH_PER_BANK; k++) begin
			if (slot[k]) begin
				ram_a		= {3'(k), wave_a[k]};
				cur_volume	= regs[k].volume;
				cur_enable	= regs[k].enable;
				cur_playing	= playing[k];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Wave RAM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (we) begin
			ram[ram_a] <= cpu_d;
		end
		ff_q <= ram[ram_a];
	end

	assign q = ff_q;

	// Settings follow the RAM data by one cycle
	always_ff @(posedge clk) begin
		ff_volume	<= cur_volume;
		ff_enable	<= cur_enable;
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_playing <= 1'b0;
		end else begin
			ff_playing <= cur_playing;
		end
	end

	wts_channel_volume u_channel_volume (
		.clk		(clk),
		.nreset		(nreset),
		.sram_q		(ff_q),
		.volume		(ff_volume),
		.enable		(ff_enable),
		.playing	(ff_playing),
		.sample		(sample)
	);

endmodule

`default_nettype wire

// File: wave_bank/wts_channel_volume.sv
/*
	Volume scaling and routing of one RAM sample.
	Result is (sample * volume) >>> 4, which always fits the sample width.
	A side whose enable bit is clear, or a silent channel, gives zero.
*/
`timescale 1ns/1ps
`default_nettype none

`include "wts_config.svh"

module wts_channel_volume import wts_pkg::*; (
	input	wire logic							clk,
	input	wire logic							nreset,
	input	wire logic	[`WTS_SAMPLE_W-1:0]		sram_q,
	input	wire logic	[`WTS_VOLUME_W-1:0]		volume,
	input	wire logic	[1:0]					enable,
	input	wire logic							playing,
	output	wts_stereo_t						sample
);

	logic signed	[`WTS_SAMPLE_W+`WTS_VOLUME_W:0]	product;
	logic signed	[`WTS_SAMPLE_W-1:0]				scaled;

	// Volume gets a zero sign bit so the multiply stays signed
	assign product	= $signed(sram_q) * $signed({1'b0, volume});
	assign scaled	= product[`WTS_SAMPLE_W+`WTS_VOLUME_W-1:`WTS_VOLUME_W];

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sample <= '0;
		end else begin
			sample.left		<= (playing && enable[1]) ? scaled : '0;
			sample.right	<= (playing && enable[0]) ? scaled : '0;
		end
	end

endmodule

`default_nettype wire

// File: channel/wts_channel_part.sv
/*
	Key state and wave address of one channel.
	The wave is a fixed 128-sample loop. The address steps only in the
	channel's own slot; key on may clear it in any cycle.
	frequency_count is sampled on key on and on every reload.
*/
`timescale 1ns/1ps
`default_nettype none

module wts_channel_part import wts_pkg::*; (
	input	wire logic			clk,
	input	wire logic			nreset,
	input	wire logic			active,
	input	wire wts_key_t		key,
	input	wire logic	[11:0]	frequency_count,
	output	logic				playing,
	output	logic		[6:0]	wave_a
);

	logic	[11:0]	ff_count;
	logic			ff_playing;
	logic	[6:0]	ff_wave_a;

	// Key on wins over key off when both arrive together
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_playing	<= 1'b0;
			ff_wave_a	<= '0;
			ff_count	<= '0;
		end else if (key.key_on) begin
			ff_playing	<= 1'b1;
			ff_wave_a	<= '0;
			ff_count	<= frequency_count;
		end else if (key.key_off) begin
			ff_playing	<= 1'b0;
		end else if (active && ff_playing) begin
			if (ff_count == '0) begin
				ff_count	<= frequency_count;
				ff_wave_a	<= ff_wave_a + 1'b1;
			end else begin
				ff_count	<= ff_count - 1'b1;
			end
		end
	end

	assign playing	= ff_playing;
	assign wave_a	= ff_wave_a;

	// Outside its slot only key on may move the address
	a_wave_a_in_slot: assert property (@(posedge clk) disable iff (!nreset)
		(!active && !key.key_on) |=> $stable(wave_a));

endmodule

`default_nettype wire

// File: common/wts_pkg.sv
/*
	Types shared by the mixer RTL and its testbench.
	Samples are two's complement, the volume is unsigned.
	enable bit 1 routes a channel to the left output, bit 0 to the right.
*/
`default_nettype none

`include "wts_config.svh"

package wts_pkg;

	// One bit per sequencer slot, exactly one set
	typedef logic [`WTS_SLOTS-1:0] wts_slot_t;

	typedef struct packed {
		logic			bank;
		logic	[2:0]	channel;
	} wts_wave_id_t;

	typedef struct packed {
		wts_wave_id_t					id;
		logic	[`WTS_WAVE_ADDR_W-1:0]	a;
		logic	[`WTS_SAMPLE_W-1:0]		d;
		logic							oe;
		logic							we;
	} wts_cpu_req_t;

	typedef struct packed {
		logic	[`WTS_VOLUME_W-1:0]	volume;
		logic	[1:0]				enable;
		logic	[`WTS_FREQ_W-1:0]	frequency_count;
	} wts_channel_reg_t;

	typedef struct packed {
		logic	key_on;
		logic	key_off;
	} wts_key_t;

	typedef struct packed {
		logic signed	[`WTS_SAMPLE_W-1:0]	left;
		logic signed	[`WTS_SAMPLE_W-1:0]	right;
	} wts_stereo_t;

endpackage

`default_nettype wire

// File: common/wts_config.svh
/*
	Build constants of the wave-table mixer.
	The slot count, the CPU slot and the channel count are tied to the one-hot
	sequencer and to the RAM address split (3-bit channel, 7-bit sample index).
	Changing one of them alone does not rescale the design.
*/

`ifndef WTS_CONFIG_SVH
`define WTS_CONFIG_SVH

// Sequencer
`define WTS_SLOTS		6
`define WTS_CPU_SLOT	5

// Channel layout
`define WTS_CH_PER_BANK	5
`define WTS_BANKS		2

// Data widths
`define WTS_WAVE_ADDR_W	7
`define WTS_SAMPLE_W	8
`define WTS_VOLUME_W	4
`define WTS_FREQ_W		12
`define WTS_OUT_W		12

`endif
